// ==== src/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath and address width
`define XLEN 32

// Architectural register count
`define NUM_REGS 32

`define RESET_PC 32'h0000_0000

// Data memory depth in words
`define DMEM_WORDS 256

`endif

// ==== src/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8
    } alu_op_e;

    // Operand source for execute
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    typedef enum logic {
        ST_RUN  = 1'b0,
        ST_HALT = 1'b1
    } core_state_e;

endpackage

`default_nettype wire

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module fetch_stage (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 stall,
    input  wire                 redirect,
    input  wire [`XLEN-1:0]     redirect_target,
    input  wire                 halt_req,
    input  wire [`XLEN-1:0]     imem_data,
    output logic [`XLEN-1:0]    imem_addr,
    output logic                if_valid,
    output logic [`XLEN-1:0]    if_pc,
    output logic [31:0]         if_inst,
    output logic                halted
);

    rv_pkg::core_state_e state;
    logic [`XLEN-1:0]    pc;
    logic                frozen;

    assign imem_addr = pc;
    assign halted    = (state == rv_pkg::ST_HALT);
    assign frozen    = halted || halt_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= rv_pkg::ST_RUN;
            pc    <= `RESET_PC;
        end else begin
            if (halt_req)
                state <= rv_pkg::ST_HALT;
            if (!frozen) begin
                // Redirect wins over stall
                if (redirect)
                    pc <= redirect_target;
                else if (!stall)
                    pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_valid <= 1'b0;
        end else if (redirect || frozen) begin
            if_valid <= 1'b0;
        end else if (!stall) begin
            if_valid <= 1'b1;
            if_pc    <= pc;
            if_inst  <= imem_data[31:0];
        end
    end

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module decode_stage (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 stall,
    input  wire                 flush,
    input  wire                 if_valid,
    input  wire [`XLEN-1:0]     if_pc,
    input  wire [31:0]          if_inst,
    input  wire                 rf_wen,
    input  wire [4:0]           rf_waddr,
    input  wire [`XLEN-1:0]     rf_wdata,
    output logic                id_valid,
    output logic [`XLEN-1:0]    id_pc,
    output logic [4:0]          id_rs1,
    output logic [4:0]          id_rs2,
    output logic [4:0]          id_rd,
    output logic [`XLEN-1:0]    id_rs1_val,
    output logic [`XLEN-1:0]    id_rs2_val,
    output logic [`XLEN-1:0]    id_imm,
    output rv_pkg::alu_op_e     id_alu_op,
    output logic                id_use_imm,
    output logic                id_reg_wen,
    output logic                id_mem_ren,
    output logic                id_mem_wen,
    output logic                id_is_beq,
    output logic                id_is_bne,
    output logic                id_is_jal,
    output logic                id_is_halt
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    rv_pkg::opcode_e  opcode;
    rv_pkg::alu_op_e  alu_op;
    logic [4:0]       rs1, rs2, rd;
    logic [2:0]       funct3;
    logic [`XLEN-1:0] imm, rs1_val, rs2_val;
    logic             use_imm, reg_wen, mem_ren, mem_wen;
    logic             is_beq, is_bne, is_jal, is_halt;

    assign opcode = rv_pkg::opcode_e'(if_inst[6:0]);
    assign rd     = if_inst[11:7];
    assign funct3 = if_inst[14:12];
    assign rs1    = if_inst[19:15];
    assign rs2    = if_inst[24:20];

    always_comb begin
        alu_op  = rv_pkg::ALU_ADD;
        imm     = '0;
        use_imm = 1'b0;
        reg_wen = 1'b0;
        mem_ren = 1'b0;
        mem_wen = 1'b0;
        is_beq  = 1'b0;
        is_bne  = 1'b0;
        is_jal  = 1'b0;
        is_halt = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                reg_wen = 1'b1;
                case (funct3)
                    3'b000: alu_op = if_inst[30] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001: alu_op = rv_pkg::ALU_SLL;
                    3'b010: alu_op = rv_pkg::ALU_SLT;
                    3'b100: alu_op = rv_pkg::ALU_XOR;
                    3'b101: alu_op = rv_pkg::ALU_SRL;
                    3'b110: alu_op = rv_pkg::ALU_OR;
                    default: alu_op = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LOAD: begin
                imm     = {{20{if_inst[31]}}, if_inst[31:20]};
                use_imm = 1'b1;
                reg_wen = 1'b1;
                mem_ren = (opcode == rv_pkg::OPC_LOAD);
            end
            rv_pkg::OPC_LUI: begin
                imm     = {if_inst[31:12], 12'b0};
                alu_op  = rv_pkg::ALU_PASS_B;
                use_imm = 1'b1;
                reg_wen = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                imm     = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
                use_imm = 1'b1;
                mem_wen = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                imm    = {{20{if_inst[31]}}, if_inst[7], if_inst[30:25],
                          if_inst[11:8], 1'b0};
                is_beq = (funct3 == 3'b000);
                is_bne = (funct3 == 3'b001);
            end
            rv_pkg::OPC_JAL: begin
                imm     = {{12{if_inst[31]}}, if_inst[19:12], if_inst[20],
                           if_inst[30:21], 1'b0};
                reg_wen = 1'b1;
                is_jal  = 1'b1;
            end
            rv_pkg::OPC_SYSTEM: is_halt = (if_inst[31:7] == 25'h2000);
            default: ;
        endcase
    end

    // Register file, write-first
    always_ff @(posedge clk) begin
        if (rf_wen && rf_waddr != 5'd0)
            regs[rf_waddr] <= rf_wdata;
    end

    assign rs1_val = (rs1 == 5'd0) ? '0 :
                     (rf_wen && rf_waddr == rs1) ? rf_wdata : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 :
                     (rf_wen && rf_waddr == rs2) ? rf_wdata : regs[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n || stall || flush || !if_valid) begin
            id_valid   <= 1'b0;
            id_reg_wen <= 1'b0;
            id_mem_ren <= 1'b0;
            id_mem_wen <= 1'b0;
            id_is_beq  <= 1'b0;
            id_is_bne  <= 1'b0;
            id_is_jal  <= 1'b0;
            id_is_halt <= 1'b0;
        end else begin
            id_valid   <= 1'b1;
            id_reg_wen <= reg_wen;
            id_mem_ren <= mem_ren;
            id_mem_wen <= mem_wen;
            id_is_beq  <= is_beq;
            id_is_bne  <= is_bne;
            id_is_jal  <= is_jal;
            id_is_halt <= is_halt;
        end
        id_pc      <= if_pc;
        id_rs1     <= rs1;
        id_rs2     <= rs2;
        id_rd      <= rd;
        id_rs1_val <= rs1_val;
        id_rs2_val <= rs2_val;
        id_imm     <= imm;
        id_alu_op  <= alu_op;
        id_use_imm <= use_imm;
    end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module execute_stage (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 id_valid,
    input  wire [`XLEN-1:0]     id_pc,
    input  wire [4:0]           id_rd,
    input  wire [`XLEN-1:0]     id_rs1_val,
    input  wire [`XLEN-1:0]     id_rs2_val,
    input  wire [`XLEN-1:0]     id_imm,
    input  rv_pkg::alu_op_e     id_alu_op,
    input  wire                 id_use_imm,
    input  wire                 id_reg_wen,
    input  wire                 id_mem_ren,
    input  wire                 id_mem_wen,
    input  wire                 id_is_beq,
    input  wire                 id_is_bne,
    input  wire                 id_is_jal,
    input  wire                 id_is_halt,
    input  rv_pkg::fwd_sel_e    fwd_a,
    input  rv_pkg::fwd_sel_e    fwd_b,
    input  wire [`XLEN-1:0]     mem_fwd_data,
    input  wire [`XLEN-1:0]     wb_fwd_data,
    output logic                redirect,
    output logic [`XLEN-1:0]    redirect_target,
    output logic                ex_valid,
    output logic [`XLEN-1:0]    ex_pc,
    output logic [4:0]          ex_rd,
    output logic                ex_reg_wen,
    output logic                ex_mem_ren,
    output logic                ex_mem_wen,
    output logic [`XLEN-1:0]    ex_result,
    output logic [`XLEN-1:0]    ex_store_data,
    output logic                ex_is_halt
);

    logic [`XLEN-1:0] op_a, rs2_fwd, op_b, alu_out;
    logic             equal;

    always_comb begin
        case (fwd_a)
            rv_pkg::FWD_MEM: op_a = mem_fwd_data;
            rv_pkg::FWD_WB:  op_a = wb_fwd_data;
            default:         op_a = id_rs1_val;
        endcase
        case (fwd_b)
            rv_pkg::FWD_MEM: rs2_fwd = mem_fwd_data;
            rv_pkg::FWD_WB:  rs2_fwd = wb_fwd_data;
            default:         rs2_fwd = id_rs2_val;
        endcase
    end

    assign op_b = id_use_imm ? id_imm : rs2_fwd;

    always_comb begin
        case (id_alu_op)
            rv_pkg::ALU_SUB:    alu_out = op_a - op_b;
            rv_pkg::ALU_AND:    alu_out = op_a & op_b;
            rv_pkg::ALU_OR:     alu_out = op_a | op_b;
            rv_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            rv_pkg::ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLL:    alu_out = op_a << op_b[4:0];
            rv_pkg::ALU_SRL:    alu_out = op_a >> op_b[4:0];
            rv_pkg::ALU_PASS_B: alu_out = op_b;
            default:            alu_out = op_a + op_b;
        endcase
    end

    // Branches resolve here
    assign equal           = (op_a == rs2_fwd);
    assign redirect        = id_valid && (id_is_jal || (id_is_beq && equal) ||
                                          (id_is_bne && !equal));
    assign redirect_target = id_pc + id_imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid   <= 1'b0;
            ex_reg_wen <= 1'b0;
            ex_mem_ren <= 1'b0;
            ex_mem_wen <= 1'b0;
            ex_is_halt <= 1'b0;
        end else begin
            ex_valid   <= id_valid;
            ex_reg_wen <= id_reg_wen;
            ex_mem_ren <= id_mem_ren;
            ex_mem_wen <= id_mem_wen;
            ex_is_halt <= id_is_halt;
        end
        ex_pc         <= id_pc;
        ex_rd         <= id_rd;
        ex_result     <= id_is_jal ? id_pc + 32'd4 : alu_out;
        ex_store_data <= rs2_fwd;
    end

endmodule

`default_nettype wire

// ==== src/mem_stage.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module mem_stage (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 ex_valid,
    input  wire [4:0]           ex_rd,
    input  wire                 ex_reg_wen,
    input  wire                 ex_mem_ren,
    input  wire                 ex_mem_wen,
    input  wire [`XLEN-1:0]     ex_result,
    input  wire [`XLEN-1:0]     ex_store_data,
    input  wire                 ex_is_halt,
    output logic                mem_valid,
    output logic [4:0]          mem_rd,
    output logic                mem_reg_wen,
    output logic [`XLEN-1:0]    mem_result,
    output logic                mem_is_halt
);

    localparam int AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] dmem [`DMEM_WORDS];
    logic [AW-1:0]    word_idx;
    logic [`XLEN-1:0] load_data;

    // Word index drops the byte offset
    assign word_idx  = ex_result[AW+1:2];
    assign load_data = dmem[word_idx];

    always_ff @(posedge clk) begin
        if (ex_valid && ex_mem_wen)
            dmem[word_idx] <= ex_store_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid   <= 1'b0;
            mem_reg_wen <= 1'b0;
            mem_is_halt <= 1'b0;
        end else begin
            mem_valid   <= ex_valid;
            mem_reg_wen <= ex_reg_wen;
            mem_is_halt <= ex_is_halt;
        end
        mem_rd     <= ex_rd;
        mem_result <= ex_mem_ren ? load_data : ex_result;
    end

endmodule

`default_nettype wire

// ==== src/writeback_stage.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module writeback_stage (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 mem_valid,
    input  wire [4:0]           mem_rd,
    input  wire                 mem_reg_wen,
    input  wire [`XLEN-1:0]     mem_result,
    input  wire                 mem_is_halt,
    output logic                rf_wen,
    output logic [4:0]          rf_waddr,
    output logic [`XLEN-1:0]    rf_wdata,
    output logic                retire_valid,
    output logic [4:0]          retire_rd,
    output logic [`XLEN-1:0]    retire_data,
    output logic                halt_req
);

    // Set once EBREAK passes, blocks everything younger
    logic stopped;

    always_ff @(posedge clk) begin
        if (!rst_n)
            stopped <= 1'b0;
        else if (mem_valid && mem_is_halt)
            stopped <= 1'b1;
    end

    assign rf_wen   = mem_valid && mem_reg_wen && (mem_rd != 5'd0) && !stopped;
    assign rf_waddr = mem_rd;
    assign rf_wdata = mem_result;

    assign retire_valid = rf_wen;
    assign retire_rd    = mem_rd;
    assign retire_data  = mem_result;
    assign halt_req     = (mem_valid && mem_is_halt) || stopped;

endmodule

`default_nettype wire

// ==== src/hazard_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard_ctrl (
    input  wire [4:0]           id_rs1,
    input  wire [4:0]           id_rs2,
    input  wire [4:0]           ex_rs1,
    input  wire [4:0]           ex_rs2,
    input  wire                 ex_valid,
    input  wire                 ex_mem_ren,
    input  wire [4:0]           ex_rd,
    input  wire                 mem_valid,
    input  wire                 mem_reg_wen,
    input  wire [4:0]           mem_rd,
    input  wire                 rf_wen,
    input  wire [4:0]           rf_waddr,
    input  wire                 redirect,
    output logic                stall,
    output logic                flush,
    output rv_pkg::fwd_sel_e    fwd_a,
    output rv_pkg::fwd_sel_e    fwd_b
);

    logic load_in_ex;
    logic mem_writes;

    assign load_in_ex = ex_valid && ex_mem_ren && (ex_rd != 5'd0);
    assign mem_writes = mem_valid && mem_reg_wen && (mem_rd != 5'd0);

    // Loaded word is ready only once the load reaches writeback
    assign stall = load_in_ex && (ex_rd == id_rs1 || ex_rd == id_rs2);

    // Fetch and decode let a redirect win over a stall
    assign flush = redirect;

    // Memory stage holds the newer value
    always_comb begin
        if (mem_writes && mem_rd == ex_rs1)
            fwd_a = rv_pkg::FWD_MEM;
        else if (rf_wen && rf_waddr == ex_rs1)
            fwd_a = rv_pkg::FWD_WB;
        else
            fwd_a = rv_pkg::FWD_NONE;
        if (mem_writes && mem_rd == ex_rs2)
            fwd_b = rv_pkg::FWD_MEM;
        else if (rf_wen && rf_waddr == ex_rs2)
            fwd_b = rv_pkg::FWD_WB;
        else
            fwd_b = rv_pkg::FWD_NONE;
    end

endmodule

`default_nettype wire

// ==== src/rv_core_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module rv_core_top (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire [`XLEN-1:0]     imem_data,
    output logic [`XLEN-1:0]    imem_addr,
    output logic                retire_valid,
    output logic [4:0]          retire_rd,
    output logic [`XLEN-1:0]    retire_data,
    output logic                halted
);

    // Fetch to decode
    logic                if_valid;
    logic [`XLEN-1:0]    if_pc;
    logic [31:0]         if_inst;

    // Decode to execute
    logic                id_valid;
    logic [`XLEN-1:0]    id_pc;
    logic [4:0]          id_rs1;
    logic [4:0]          id_rs2;
    logic [4:0]          id_rd;
    logic [`XLEN-1:0]    id_rs1_val;
    logic [`XLEN-1:0]    id_rs2_val;
    logic [`XLEN-1:0]    id_imm;
    rv_pkg::alu_op_e     id_alu_op;
    logic                id_use_imm;
    logic                id_reg_wen;
    logic                id_mem_ren;
    logic                id_mem_wen;
    logic                id_is_beq;
    logic                id_is_bne;
    logic                id_is_jal;
    logic                id_is_halt;

    // Execute to memory
    logic                ex_valid;
    logic [4:0]          ex_rd;
    logic                ex_reg_wen;
    logic                ex_mem_ren;
    logic                ex_mem_wen;
    logic [`XLEN-1:0]    ex_result;
    logic [`XLEN-1:0]    ex_store_data;
    logic                ex_is_halt;

    // Memory to writeback
    logic                mem_valid;
    logic [4:0]          mem_rd;
    logic                mem_reg_wen;
    logic [`XLEN-1:0]    mem_result;
    logic                mem_is_halt;

    logic                rf_wen;
    logic [4:0]          rf_waddr;
    logic [`XLEN-1:0]    rf_wdata;
    logic                halt_req;
    logic                stall;
    logic                flush;
    logic                redirect;
    logic [`XLEN-1:0]    redirect_target;
    rv_pkg::fwd_sel_e    fwd_a;
    rv_pkg::fwd_sel_e    fwd_b;

    fetch_stage u_fetch (.*);

    decode_stage u_decode (.*);

    // Loads are forwarded only from writeback
    execute_stage u_execute (
        .ex_pc        (),
        .mem_fwd_data (ex_result),
        .wb_fwd_data  (rf_wdata),
        .*
    );

    mem_stage u_mem (.*);

    writeback_stage u_writeback (.*);

    // Hazard ports name the stage each instruction occupies
    hazard_ctrl u_hazard (
        .id_rs1      (if_inst[19:15]),
        .id_rs2      (if_inst[24:20]),
        .ex_rs1      (id_rs1),
        .ex_rs2      (id_rs2),
        .ex_valid    (id_valid),
        .ex_mem_ren  (id_mem_ren),
        .ex_rd       (id_rd),
        .mem_valid   (ex_valid),
        .mem_reg_wen (ex_reg_wen),
        .mem_rd      (ex_rd),
        .rf_wen      (rf_wen),
        .rf_waddr    (rf_waddr),
        .redirect    (redirect),
        .stall       (stall),
        .flush       (flush),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b)
    );

endmodule

`default_nettype wire

// ==== verif/rv_core_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_assert (
    input wire       clk,
    input wire       rst_n,
    input wire       stall,
    input wire       redirect,
    input wire       halted,
    input wire       retire_valid,
    input wire [4:0] retire_rd
);

    // A load in execute never redirects
    a_no_stall_with_redirect: assert property (
        @(posedge clk) disable iff (!rst_n) !(stall && redirect))
        else $error("stall and redirect high in the same cycle");

    a_halt_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> halted)
        else $error("halted fell without a reset");

    a_retire_rd_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n) retire_valid |-> (retire_rd != 5'd0))
        else $error("retire reported for x0");

endmodule

bind rv_core_top rv_core_assert u_assert (
    .clk(clk),
    .rst_n(rst_n),
    .stall(stall),
    .redirect(redirect),
    .halted(halted),
    .retire_valid(retire_valid),
    .retire_rd(retire_rd)
);

`default_nettype wire

// ==== verif/tb_rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module tb_rv_core;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 200;

    logic             clk;
    logic             rst_n;
    logic [`XLEN-1:0] imem_data;
    logic [`XLEN-1:0] imem_addr;
    logic             retire_valid;
    logic [4:0]       retire_rd;
    logic [`XLEN-1:0] retire_data;
    logic             halted;

    logic [31:0]      imem [256];
    logic [4:0]       got_rd [$];
    logic [4:0]       exp_rd [$];
    logic [`XLEN-1:0] got_val [$];
    logic [`XLEN-1:0] exp_val [$];
    int               errors;
    int               checks;
    int               seed;
    int               pc_w;

    rv_core_top u_dut (
        .clk(clk),
        .rst_n(rst_n),
        .imem_data(imem_data),
        .imem_addr(imem_addr),
        .retire_valid(retire_valid),
        .retire_rd(retire_rd),
        .retire_data(retire_data),
        .halted(halted)
    );

    // Instruction memory answers in the same cycle
    assign imem_data = imem[imem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // RV32I encodings
    function automatic logic [31:0] r_op(input int f7, input int f3, input int rd,
                                         input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] lui(input int rd, input logic [19:0] imm20);
        return {imm20, rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input int off);
        return {off[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] ebreak();
        return 32'h0010_0073;
    endfunction

    task automatic emit(input logic [31:0] inst);
        imem[pc_w[7:0]] = inst;
        pc_w++;
    endtask

    task automatic step(input logic [31:0] inst, input int rd, input logic [31:0] val);
        emit(inst);
        exp_rd.push_back(rd[4:0]);
        exp_val.push_back(val);
    endtask

    // LUI rounds up so that the sign-extended ADDI lands on val
    task automatic load_imm(input int rd, input logic [31:0] val);
        logic [31:0] upper;
        upper = val + 32'h800;
        step(lui(rd, upper[31:12]), rd, {upper[31:12], 12'b0});
        step(addi(rd, rd, val), rd, val);
    endtask

    always @(negedge clk) begin
        if (rst_n === 1'b1 && retire_valid === 1'b1) begin
            got_rd.push_back(retire_rd);
            got_val.push_back(retire_data);
        end
    end

    task automatic start_test();
        int i;
        // NOPs whose immediate carries the word index
        for (i = 0; i < 256; i++)
            imem[i[7:0]] = addi(0, 0, i);
        pc_w = 0;
        got_rd.delete();
        got_val.delete();
        exp_rd.delete();
        exp_val.delete();
        @(posedge clk);
        rst_n <= 1'b0;
    endtask

    task automatic run_program(input string name);
        int n;
        int i;
        n = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        while (halted !== 1'b1 && n < TEST_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (halted !== 1'b1) begin
            $display("ERROR: %s did not halt within %0d cycles", name, TEST_CYCLES);
            errors++;
        end
        checks++;
        if (got_rd.size() != exp_rd.size()) begin
            $display("Mismatch at %0t: %s retired %0d register writes, expected %0d",
                     $time, name, got_rd.size(), exp_rd.size());
            errors++;
        end
        for (i = 0; i < exp_rd.size() && i < got_rd.size(); i++) begin
            checks++;
            if (got_rd[i] !== exp_rd[i] || got_val[i] !== exp_val[i]) begin
                $display("Mismatch at %0t: %s retire %0d got x%0d=%h, expected x%0d=%h",
                         $time, name, i, got_rd[i], got_val[i], exp_rd[i], exp_val[i]);
                errors++;
            end
        end
    endtask

    task automatic alu_chain_test();
        logic [31:0] v [12];
        start_test();
        v[1] = $random(seed) % 2048;
        // Negative operand so that SLT sees a sign difference
        v[2] = 32'hFFFF_F800 | ($random(seed) & 32'h7FF);
        v[3] = v[1] + v[2];
        v[4] = v[3] - v[1];
        v[5] = v[4] ^ v[3];
        v[6] = 32'd3;
        v[7] = v[5] << 3;
        v[8] = v[7] >> 3;
        v[9] = ($signed(v[4]) < $signed(v[6])) ? 32'd1 : 32'd0;
        v[10] = v[8] & v[7];
        v[11] = v[10] | v[4];
        step(addi(1, 0, v[1]), 1, v[1]);
        step(addi(2, 0, v[2]), 2, v[2]);
        step(r_op(0, 0, 3, 1, 2), 3, v[3]);
        step(r_op(32, 0, 4, 3, 1), 4, v[4]);
        step(r_op(0, 4, 5, 4, 3), 5, v[5]);
        step(addi(6, 0, v[6]), 6, v[6]);
        step(r_op(0, 1, 7, 5, 6), 7, v[7]);
        step(r_op(0, 5, 8, 7, 6), 8, v[8]);
        step(r_op(0, 2, 9, 4, 6), 9, v[9]);
        step(r_op(0, 7, 10, 8, 7), 10, v[10]);
        step(r_op(0, 6, 11, 10, 4), 11, v[11]);
        emit(ebreak());
        run_program("alu chain");
    endtask

    task automatic load_use_test();
        logic [31:0] w;
        start_test();
        w = $random(seed);
        load_imm(1, w);
        step(addi(2, 0, 64), 2, 64);
        emit(sw(1, 2, 4));
        step(lw(3, 2, 4), 3, w);
        step(r_op(0, 0, 4, 3, 1), 4, w + w);
        emit(ebreak());
        run_program("load use");
    endtask

    task automatic branch_test();
        start_test();
        step(addi(1, 0, 5), 1, 5);
        step(addi(2, 0, 5), 2, 5);
        emit(branch(0, 1, 2, 12));
        emit(addi(3, 0, 1));
        emit(addi(3, 0, 2));
        emit(branch(1, 1, 2, 12));
        step(addi(4, 0, 7), 4, 7);
        step(addi(2, 0, 6), 2, 6);
        emit(branch(1, 1, 2, 12));
        emit(addi(5, 0, 1));
        emit(addi(5, 0, 2));
        emit(branch(0, 1, 2, 8));
        step(addi(6, 0, 9), 6, 9);
        emit(ebreak());
        run_program("branches");
    endtask

    task automatic jal_x0_test();
        start_test();
        step(jal(1, 12), 1, 4);
        emit(addi(2, 0, 1));
        emit(addi(2, 0, 2));
        emit(addi(0, 0, 5));
        step(r_op(0, 0, 3, 0, 1), 3, 4);
        emit(addi(0, 1, 100));
        step(r_op(0, 0, 4, 0, 0), 4, 0);
        emit(jal(0, 8));
        emit(addi(5, 0, 1));
        emit(ebreak());
        run_program("jal and x0");
    endtask

    task automatic random_ops_test();
        logic [31:0] a;
        logic [31:0] b;
        start_test();
        a = $random(seed);
        b = $random(seed);
        load_imm(1, a);
        load_imm(2, b);
        step(r_op(0, 0, 3, 1, 2), 3, a + b);
        step(r_op(32, 0, 4, 1, 2), 4, a - b);
        step(r_op(0, 4, 5, 1, 2), 5, a ^ b);
        emit(ebreak());
        run_program("random operands");
    endtask

    task automatic halt_hold_test();
        start_test();
        step(addi(1, 0, 11), 1, 11);
        emit(ebreak());
        emit(addi(2, 0, 22));
        emit(addi(3, 0, 33));
        emit(jal(0, -8));
        run_program("halt hold");
        repeat (20) begin
            @(negedge clk);
            checks++;
            if (halted !== 1'b1 || retire_valid !== 1'b0) begin
                $display("Mismatch at %0t: core left halt, halted=%b retire_valid=%b",
                         $time, halted, retire_valid);
                errors++;
            end
        end
    endtask

    initial begin
        #(NUM_TESTS * (TEST_CYCLES + 30) * CLK_PERIOD);
        $display("ERROR: watchdog expired before the tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst_n  = 1'b0;
        errors = 0;
        checks = 0;
        seed   = 53;
        pc_w   = 0;
        alu_chain_test();
        load_use_test();
        branch_test();
        jal_x0_test();
        random_ops_test();
        halt_hold_test();
        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+src
src/rv_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_stage.sv
src/writeback_stage.sv
src/hazard_ctrl.sv
src/rv_core_top.sv
verif/rv_core_assert.sv
verif/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the RV32I core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module tb_rv_core -Mdir obj_dir &&
out="$(./obj_dir/Vtb_rv_core)"
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED" && exit 0 ||
{ echo "Simulation did not pass"; exit 1; }
